// File: src.f
+incdir+.
adapt_reg_pkg.sv
adapt_sr_pkg.sv
sr_if.sv
async_update.sv
hip_async_update.sv
sr_ctrl.sv
sr_parity_check.sv
hip_sr_top.sv
tb_hip_sr.sv

// File: run.sh
#!/bin/sh
# Build and run the status path testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 -f src.f --top-module tb_hip_sr -o Vtb_hip_sr

status=0
out=$(./obj_dir/Vtb_hip_sr) || status=$?
printf '%s\n' "$out"

if [ "$status" -eq 0 ] && printf '%s\n' "$out" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1

// File: tb_hip_sr.sv
// Status return path testbench
`include "adapt_defines.svh"

module tb_hip_sr;
    import adapt_reg_pkg::*;

    localparam int N_ITER          = 100;
    localparam int N_AUTO          = 20;
    localparam int ACK_LIMIT       = 8;
    localparam int WATCHDOG_CYCLES = (N_ITER + N_AUTO) * 200 + 500;

    logic                    osc_clk;
    logic                    arst_n;
    logic                    wb_cyc;
    logic                    wb_stb;
    logic                    wb_we;
    logic [`ADAPT_WB_AW-1:0] wb_adr;
    logic [`ADAPT_WB_DW-1:0] wb_dat_w;
    logic [`ADAPT_WB_DW-1:0] wb_dat_r;
    logic                    wb_ack;
    logic [`ADAPT_FSR_W-1:0] hip_fsr_async;
    logic [`ADAPT_SSR_W-1:0] hip_ssr_async;
    logic [`ADAPT_FSR_W-1:0] fsr_out;
    logic [`ADAPT_SSR_W-1:0] ssr_out;

    logic [31:0] lfsr_state;

    // Reference model state
    logic [3:0] m_rst_val;
    logic       m_fsr_loaded;
    logic [3:0] m_fsr;
    logic [7:0] m_ssr;
    int         m_fsr_cnt;
    int         m_ssr_cnt;

    hip_sr_top u_dut (
        .osc_clk       (osc_clk),
        .arst_n        (arst_n),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_adr        (wb_adr),
        .wb_dat_w      (wb_dat_w),
        .wb_dat_r      (wb_dat_r),
        .wb_ack        (wb_ack),
        .hip_fsr_async (hip_fsr_async),
        .hip_ssr_async (hip_ssr_async),
        .fsr_out       (fsr_out),
        .ssr_out       (ssr_out)
    );

    initial begin
        osc_clk = 1'b0;
        forever #10 osc_clk = ~osc_clk;
    end

    // x^32 + x^22 + x^2 + x + 1, right shifting
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Reset value per bit holds until the first FSR capture
    function automatic logic [3:0] expected_fsr();
        return m_fsr_loaded ? m_fsr : m_rst_val;
    endfunction

    function automatic logic [31:0] expected_status();
        return {20'h0, m_ssr, expected_fsr()};
    endfunction

    function automatic logic [31:0] expected_errcnt();
        return {16'h0, 8'(m_ssr_cnt), 8'(m_fsr_cnt)};
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped on failure");
    endtask

    task automatic expect_equal(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            fail_run($sformatf("ERROR %0t: %s got %h expected %h", $time, what, got, exp));
        end
    endtask

    task automatic next_cycle();
        @(posedge osc_clk);
        #2;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic wait_ack();
        int n;
        n = 0;
        do begin
            next_cycle();
            n++;
            assert (n < ACK_LIMIT) else begin
                fail_run("the Wishbone slave never answered with an ack");
            end
        end while (!wb_ack);
    endtask

    task automatic wb_write(input logic [2:0] addr, input logic [31:0] data);
        next_cycle();
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = addr;
        wb_dat_w = data;
        wait_ack();
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_read(input logic [2:0] addr, output logic [31:0] data);
        next_cycle();
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = addr;
        wait_ack();
        data   = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic drive_status(input logic [3:0] fsr, input logic [7:0] ssr);
        hip_fsr_async = fsr;
        hip_ssr_async = ssr;
    endtask

    // Capture and parity rules applied to the held inputs
    task automatic model_load(input logic [1:0] ld);
        if (ld[0]) begin
            m_fsr        = hip_fsr_async;
            m_fsr_loaded = 1'b1;
            if (m_fsr[0] && m_fsr_cnt < 255) begin
                m_fsr_cnt++;
            end
        end
        if (ld[1]) begin
            m_ssr = hip_ssr_async;
            if (((^m_ssr[5:0]) != m_ssr[6]) && m_ssr_cnt < 255) begin
                m_ssr_cnt++;
            end
        end
    endtask

    task automatic check_outputs(input string tag);
        expect_equal({tag, " fsr_out"}, 32'(fsr_out), 32'(expected_fsr()));
        expect_equal({tag, " ssr_out"}, 32'(ssr_out), 32'(m_ssr));
    endtask

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge osc_clk);
        fail_run("watchdog timeout, the test did not finish in time");
    end

    initial begin
        logic [31:0] rd;
        logic [3:0]  new_fsr;
        logic [7:0]  new_ssr;
        logic [5:0]  sat_data;
        logic [1:0]  ld;
        logic        hit;
        int          period;
        int          p_eff;

        lfsr_state    = 32'had1f;
        arst_n        = 1'b0;
        wb_cyc        = 1'b0;
        wb_stb        = 1'b0;
        wb_we         = 1'b0;
        wb_adr        = '0;
        wb_dat_w      = '0;
        hip_fsr_async = '0;
        hip_ssr_async = '0;
        m_rst_val     = '0;
        m_fsr_loaded  = 1'b0;
        m_fsr         = '0;
        m_ssr         = '0;
        m_fsr_cnt     = 0;
        m_ssr_cnt     = 0;
        repeat (4) @(posedge osc_clk);
        #2;
        arst_n = 1'b1;

        // Reset state, then reset value select before any load
        check_outputs("reset");
        wb_read(STATUS, rd);
        expect_equal("reset STATUS", rd, 32'h0);
        wb_read(ERRCNT, rd);
        expect_equal("reset ERRCNT", rd, 32'h0);
        m_rst_val = 4'(rand_bits(4));
        wb_write(CTRL, {27'h0, 1'b0, m_rst_val});
        next_cycle();
        check_outputs("rst_val");
        wb_read(STATUS, rd);
        expect_equal("rst_val STATUS", rd, expected_status());

        for (int it = 0; it < N_ITER; it++) begin
            next_cycle();
            drive_status(4'(rand_bits(4)), 8'(rand_bits(8)));
            wait_cycles(4);
            ld = 2'(rand_bits(2));
            wb_write(LOAD, {30'h0, ld});
            model_load(ld);
            next_cycle();
            check_outputs("load");
            wb_read(STATUS, rd);
            expect_equal("STATUS", rd, expected_status());

            // New inputs without a load must not reach the outputs
            next_cycle();
            drive_status(4'(rand_bits(4)), 8'(rand_bits(8)));
            wait_cycles(4);
            check_outputs("no load");
            wb_read(ERRCNT, rd);
            expect_equal("ERRCNT", rd, expected_errcnt());

            if (it == N_ITER / 2) begin
                wb_write(ERRCNT, rand_bits(32));
                m_fsr_cnt = 0;
                m_ssr_cnt = 0;
                wb_read(ERRCNT, rd);
                expect_equal("ERRCNT clear", rd, expected_errcnt());
            end
        end

        // Periodic loads
        period = int'(rand_bits(3));
        p_eff  = (period == 0) ? 1 : period;
        wb_write(PERIOD, 32'(period));
        wb_write(CTRL, {27'h0, 1'b1, m_rst_val});
        for (int it = 0; it < N_AUTO; it++) begin
            new_fsr = 4'(rand_bits(4));
            new_ssr = 8'(rand_bits(8));
            next_cycle();
            drive_status(new_fsr, new_ssr);
            hit = 1'b0;
            for (int k = 0; k < period + 4 && !hit; k++) begin
                next_cycle();
                hit = (fsr_out == new_fsr) && (ssr_out == new_ssr);
            end
            assert (hit) else begin
                fail_run($sformatf("ERROR %0t: outputs missed %h %h within %0d cycles",
                                   $time, new_fsr, new_ssr, period + 4));
            end
            m_fsr        = new_fsr;
            m_ssr        = new_ssr;
            m_fsr_loaded = 1'b1;
            wb_read(STATUS, rd);
            expect_equal("auto STATUS", rd, expected_status());
        end

        // Held bad parity on both words drives the counts into saturation
        sat_data = 6'(rand_bits(6));
        next_cycle();
        drive_status({3'(rand_bits(3)), 1'b1}, {1'b0, ~(^sat_data), sat_data});
        wb_write(ERRCNT, 32'h0);
        wait_cycles(256 * (p_eff + 1) + 16);
        m_fsr_cnt = 255;
        m_ssr_cnt = 255;
        wb_read(ERRCNT, rd);
        expect_equal("ERRCNT saturated", rd, expected_errcnt());
        wait_cycles(4 * (p_eff + 1));
        wb_read(ERRCNT, rd);
        expect_equal("ERRCNT held", rd, expected_errcnt());

        wb_write(CTRL, {27'h0, 1'b0, m_rst_val});
        wait_cycles(4);
        wb_write(ERRCNT, 32'h0);
        m_fsr_cnt = 0;
        m_ssr_cnt = 0;
        wb_read(ERRCNT, rd);
        expect_equal("ERRCNT final clear", rd, expected_errcnt());

        $display("TEST PASS");
        $finish;
    end

endmodule

// File: hip_sr_top.sv
// Status return path top
`include "adapt_defines.svh"

module hip_sr_top (
    input  logic                    osc_clk,
    input  logic                    arst_n,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  logic [`ADAPT_WB_AW-1:0] wb_adr,
    input  logic [`ADAPT_WB_DW-1:0] wb_dat_w,
    output logic [`ADAPT_WB_DW-1:0] wb_dat_r,
    output logic                    wb_ack,
    input  logic [`ADAPT_FSR_W-1:0] hip_fsr_async,
    input  logic [`ADAPT_SSR_W-1:0] hip_ssr_async,
    output logic [`ADAPT_FSR_W-1:0] fsr_out,
    output logic [`ADAPT_SSR_W-1:0] ssr_out
);
    import adapt_sr_pkg::*;

    errcnt_t fsr_errcnt;
    errcnt_t ssr_errcnt;
    logic    errcnt_clr;

    sr_if sr_bus ();

    sr_ctrl u_ctrl (
        .osc_clk    (osc_clk),
        .arst_n     (arst_n),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .fsr_errcnt (fsr_errcnt),
        .ssr_errcnt (ssr_errcnt),
        .sr         (sr_bus.ctrl),
        .errcnt_clr (errcnt_clr)
    );

    hip_async_update u_update (
        .osc_clk       (osc_clk),
        .arst_n        (arst_n),
        .hip_fsr_async (fsr_t'(hip_fsr_async)),
        .hip_ssr_async (ssr_t'(hip_ssr_async)),
        .sr            (sr_bus.update)
    );

    sr_parity_check u_check (
        .osc_clk    (osc_clk),
        .arst_n     (arst_n),
        .sr         (sr_bus.check),
        .errcnt_clr (errcnt_clr),
        .fsr_errcnt (fsr_errcnt),
        .ssr_errcnt (ssr_errcnt)
    );

    // Captured status straight to the fabric
    assign fsr_out = sr_bus.fsr_q;
    assign ssr_out = sr_bus.ssr_q;

endmodule

// File: sr_parity_check.sv
// Status parity error counters
module sr_parity_check (
    input  logic                  osc_clk,
    input  logic                  arst_n,
    sr_if.check                   sr,
    input  logic                  errcnt_clr,
    output adapt_sr_pkg::errcnt_t fsr_errcnt,
    output adapt_sr_pkg::errcnt_t ssr_errcnt
);
    import adapt_sr_pkg::*;

    localparam errcnt_t CNT_MAX = '1;

    logic ssr_par_err;
    logic fsr_par_err;

    // Bit 0 of the FSR is the fast parity flag from the IP
    assign ssr_par_err = sr.ssr_upd && ((^sr.ssr_q.data) != sr.ssr_q.par);
    assign fsr_par_err = sr.fsr_upd && sr.fsr_q[0];

    always_ff @(posedge osc_clk or negedge arst_n) begin
        if (!arst_n) begin
            fsr_errcnt <= '0;
            ssr_errcnt <= '0;
        end else if (errcnt_clr) begin
            fsr_errcnt <= '0;
            ssr_errcnt <= '0;
        end else begin
            if (fsr_par_err && fsr_errcnt != CNT_MAX) begin
                fsr_errcnt <= fsr_errcnt + 1'b1;
            end
            if (ssr_par_err && ssr_errcnt != CNT_MAX) begin
                ssr_errcnt <= ssr_errcnt + 1'b1;
            end
        end
    end

    a_fsr_saturates: assert property (
        @(posedge osc_clk) disable iff (!arst_n)
        (fsr_errcnt == CNT_MAX && !errcnt_clr) |=> fsr_errcnt == CNT_MAX
    );

    a_ssr_saturates: assert property (
        @(posedge osc_clk) disable iff (!arst_n)
        (ssr_errcnt == CNT_MAX && !errcnt_clr) |=> ssr_errcnt == CNT_MAX
    );

endmodule

// File: sr_ctrl.sv
// Wishbone control for the status path
`include "adapt_defines.svh"

module sr_ctrl (
    input  logic                    osc_clk,
    input  logic                    arst_n,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  logic [`ADAPT_WB_AW-1:0] wb_adr,
    input  logic [`ADAPT_WB_DW-1:0] wb_dat_w,
    output logic [`ADAPT_WB_DW-1:0] wb_dat_r,
    output logic                    wb_ack,
    input  adapt_sr_pkg::errcnt_t   fsr_errcnt,
    input  adapt_sr_pkg::errcnt_t   ssr_errcnt,
    sr_if.ctrl                      sr,
    output logic                    errcnt_clr
);
    import adapt_reg_pkg::*;

    localparam int PERIOD_W = 16;
    localparam int CNT_W    = `ADAPT_ERRCNT_W;

    ctrl_reg_t               ctrl_q;
    ctrl_reg_t               ctrl_wr;
    logic [PERIOD_W-1:0]     period_q;
    logic [PERIOD_W-1:0]     period_eff;
    logic [PERIOD_W-1:0]     tick_cnt;
    logic                    auto_tick;
    logic                    access;
    logic                    wr_en;
    reg_addr_e               addr;
    logic [`ADAPT_WB_DW-1:0] rd_data;
    logic                    fsr_load_q;
    logic                    ssr_load_q;

    // Single-cycle classic handshake
    assign access  = wb_cyc && wb_stb && !wb_ack;
    assign wr_en   = access && wb_we;
    assign addr    = reg_addr_e'(wb_adr);
    assign ctrl_wr = ctrl_reg_t'(wb_dat_w);

    always_ff @(posedge osc_clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_ack     <= 1'b0;
            ctrl_q     <= '0;
            period_q   <= '0;
            errcnt_clr <= 1'b0;
        end else begin
            wb_ack     <= access;
            errcnt_clr <= wr_en && (addr == ERRCNT);
            if (wr_en && addr == CTRL) begin
                ctrl_q.fsr_rst_val <= ctrl_wr.fsr_rst_val;
                ctrl_q.auto_en     <= ctrl_wr.auto_en;
            end
            if (wr_en && addr == PERIOD) begin
                period_q <= wb_dat_w[PERIOD_W-1:0];
            end
        end
    end

    // Periodic tick every period_eff+1 cycles
    assign period_eff = (period_q == '0) ? PERIOD_W'(1) : period_q;
    assign auto_tick  = ctrl_q.auto_en && (tick_cnt >= period_eff);

    always_ff @(posedge osc_clk or negedge arst_n) begin
        if (!arst_n) begin
            tick_cnt <= '0;
        end else if (!ctrl_q.auto_en || auto_tick) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    // Load pulses land in the ack cycle
    always_ff @(posedge osc_clk or negedge arst_n) begin
        if (!arst_n) begin
            fsr_load_q <= 1'b0;
            ssr_load_q <= 1'b0;
        end else begin
            fsr_load_q <= auto_tick || (wr_en && addr == LOAD && wb_dat_w[0]);
            ssr_load_q <= auto_tick || (wr_en && addr == LOAD && wb_dat_w[1]);
        end
    end

    assign sr.fsr_load    = fsr_load_q;
    assign sr.ssr_load    = ssr_load_q;
    assign sr.fsr_rst_val = ctrl_q.fsr_rst_val;

    always_comb begin
        rd_data = '0;
        case (addr)
            CTRL: begin
                rd_data = ctrl_q;
            end
            PERIOD: begin
                rd_data[PERIOD_W-1:0] = period_q;
            end
            STATUS: begin
                rd_data[`ADAPT_FSR_W-1:0]           = sr.fsr_q;
                rd_data[`ADAPT_FSR_W +: `ADAPT_SSR_W] = sr.ssr_q;
            end
            ERRCNT: begin
                rd_data[0 +: CNT_W]     = fsr_errcnt;
                rd_data[CNT_W +: CNT_W] = ssr_errcnt;
            end
            default: begin
                rd_data = '0;
            end
        endcase
    end

    always_ff @(posedge osc_clk) begin
        if (access) begin
            wb_dat_r <= rd_data;
        end
    end

    a_ack_needs_req: assert property (
        @(posedge osc_clk) disable iff (!arst_n)
        $rose(wb_ack) |-> $past(wb_cyc && wb_stb)
    );

endmodule

// File: hip_async_update.sv
// FSR and SSR capture from the hard IP
`include "adapt_defines.svh"

module hip_async_update (
    input  logic               osc_clk,
    input  logic               arst_n,
    input  adapt_sr_pkg::fsr_t hip_fsr_async,
    input  adapt_sr_pkg::ssr_t hip_ssr_async,
    sr_if.update               sr
);
    import adapt_sr_pkg::*;

    fsr_t fsr_rst0;
    fsr_t fsr_rst1;
    fsr_t fsr_q;
    ssr_t ssr_q;
    logic fsr_upd_q;
    logic ssr_upd_q;

    // Two copies per FSR bit, one for each reset value
    for (genvar i = 0; i < `ADAPT_FSR_W; i++) begin : g_fsr_bit
        async_update #(
            .AWIDTH    (1),
            .RESET_VAL (1'b0)
        ) u_fsr_rst0 (
            .osc_clk        (osc_clk),
            .arst_n         (arst_n),
            .sr_load        (sr.fsr_load),
            .async_data_in  (hip_fsr_async[i]),
            .async_data_out (fsr_rst0[i])
        );

        async_update #(
            .AWIDTH    (1),
            .RESET_VAL (1'b1)
        ) u_fsr_rst1 (
            .osc_clk        (osc_clk),
            .arst_n         (arst_n),
            .sr_load        (sr.fsr_load),
            .async_data_in  (hip_fsr_async[i]),
            .async_data_out (fsr_rst1[i])
        );

        assign fsr_q[i] = sr.fsr_rst_val[i] ? fsr_rst1[i] : fsr_rst0[i];
    end

    // Slow status word as one block
    async_update #(
        .AWIDTH    (`ADAPT_SSR_W),
        .RESET_VAL ('0)
    ) u_ssr (
        .osc_clk        (osc_clk),
        .arst_n         (arst_n),
        .sr_load        (sr.ssr_load),
        .async_data_in  (hip_ssr_async),
        .async_data_out (ssr_q)
    );

    // Update flags trail capture by one cycle
    always_ff @(posedge osc_clk or negedge arst_n) begin
        if (!arst_n) begin
            fsr_upd_q <= 1'b0;
            ssr_upd_q <= 1'b0;
        end else begin
            fsr_upd_q <= sr.fsr_load;
            ssr_upd_q <= sr.ssr_load;
        end
    end

    assign sr.fsr_q   = fsr_q;
    assign sr.ssr_q   = ssr_q;
    assign sr.fsr_upd = fsr_upd_q;
    assign sr.ssr_upd = ssr_upd_q;

endmodule

// File: async_update.sv
// Synchronizer with load-gated capture
`include "adapt_defines.svh"

module async_update #(
    parameter int                AWIDTH    = 1,
    parameter logic [AWIDTH-1:0] RESET_VAL = '0
) (
    input  logic              osc_clk,
    input  logic              arst_n,
    input  logic              sr_load,
    input  logic [AWIDTH-1:0] async_data_in,
    output logic [AWIDTH-1:0] async_data_out
);
    localparam int STAGES = `ADAPT_SYNC_STAGES;

    logic [AWIDTH-1:0] sync_q [STAGES];

    // Metastability chain
    always_ff @(posedge osc_clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < STAGES; i++) begin
                sync_q[i] <= RESET_VAL;
            end
        end else begin
            sync_q[0] <= async_data_in;
            for (int i = 1; i < STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    // Capture only on the load strobe
    always_ff @(posedge osc_clk or negedge arst_n) begin
        if (!arst_n) begin
            async_data_out <= RESET_VAL;
        end else if (sr_load) begin
            async_data_out <= sync_q[STAGES-1];
        end
    end

    a_hold_without_load: assert property (
        @(posedge osc_clk) disable iff (!arst_n)
        !sr_load |=> $stable(async_data_out)
    );

endmodule

// File: sr_if.sv
// Status register strobe and capture bundle
interface sr_if;
    import adapt_sr_pkg::*;

    fsr_t fsr_rst_val;
    logic fsr_load;
    logic ssr_load;
    fsr_t fsr_q;
    ssr_t ssr_q;
    logic fsr_upd;
    logic ssr_upd;

    modport ctrl (
        output fsr_rst_val,
        output fsr_load,
        output ssr_load,
        input  fsr_q,
        input  ssr_q
    );

    modport update (
        input  fsr_rst_val,
        input  fsr_load,
        input  ssr_load,
        output fsr_q,
        output ssr_q,
        output fsr_upd,
        output ssr_upd
    );

    modport check (
        input fsr_q,
        input ssr_q,
        input fsr_upd,
        input ssr_upd
    );

endinterface

// File: adapt_sr_pkg.sv
// Status payload types
`include "adapt_defines.svh"

package adapt_sr_pkg;

    typedef logic [`ADAPT_FSR_W-1:0] fsr_t;

    // Slow status word, par covers data
    typedef struct packed {
        logic       spare;
        logic       par;
        logic [5:0] data;
    } ssr_t;

    typedef logic [`ADAPT_ERRCNT_W-1:0] errcnt_t;

endpackage

// File: adapt_reg_pkg.sv
// Control register map
`include "adapt_defines.svh"

package adapt_reg_pkg;

    // Word addresses on the Wishbone slave
    typedef enum logic [`ADAPT_WB_AW-1:0] {
        CTRL   = 3'd0,
        PERIOD = 3'd1,
        LOAD   = 3'd2,
        STATUS = 3'd3,
        ERRCNT = 3'd4
    } reg_addr_e;

    // CTRL word, upper bits read as zero
    typedef struct packed {
        logic [`ADAPT_WB_DW-`ADAPT_FSR_W-2:0] rsvd;
        logic                                 auto_en;
        logic [`ADAPT_FSR_W-1:0]              fsr_rst_val;
    } ctrl_reg_t;

endpackage

// File: adapt_defines.svh
// Adapter status path widths
`ifndef ADAPT_DEFINES_SVH
`define ADAPT_DEFINES_SVH

// Hard IP status register widths
`define ADAPT_FSR_W 4
`define ADAPT_SSR_W 8

// Flops between the async pins and capture
`define ADAPT_SYNC_STAGES 2

// Saturating parity error counters
`define ADAPT_ERRCNT_W 8

// Wishbone word address and data widths
`define ADAPT_WB_AW 3
`define ADAPT_WB_DW 32

`endif
